/* astro_input.f */
+incdir+.
astro_bus_pkg.sv
astro_ctrl_pkg.sv
host_config_regs.sv
ps2_button_decoder.sv
switch_matrix.sv
astro_input_top.sv
tb_astro_input.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the player input testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f astro_input.f \
	--top-module tb_astro_input -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

/* tb_astro_input_ref.svh */
/* Player input reference model
   Expected row byte per game and column, and the value check */

`ifndef TB_ASTRO_INPUT_REF_SVH
`define TB_ASTRO_INPUT_REF_SVH

	// Stick nibble R, L, D, U with closed switch reading 0
	function automatic logic [3:0] stick_nibble(input astro_ctrl_pkg::player_btn_t b);
		return {~b.right, ~b.left, ~b.down, ~b.up};
	endfunction

	// Row byte from the per-game column tables
	function automatic logic [7:0] expected_row(
		input logic [7:0]                  game_id,
		input logic [7:0]                  col,
		input logic [7:0]                  opt,
		input logic [7:0]                  bank3,
		input astro_ctrl_pkg::player_btn_t p1,
		input astro_ctrl_pkg::player_btn_t p2,
		input logic                        busy
	);
		logic [7:0] c0;
		logic [7:0] c1;
		logic [7:0] c2;
		case (game_id)
			// Space Zap
			8'd3: begin
				c0 = {2'b11, ~p2.start, ~p1.start, opt[1], 1'b1, ~p1.coin, 1'b1};
				c1 = {3'b111, ~p2.fire1, stick_nibble(p2)};
				c2 = {2'b11, opt[0], ~p1.fire1, stick_nibble(p1)};
			end
			// Gorf
			8'd4: begin
				c0 = {opt[2], opt[0], ~p2.start, ~p1.start, 1'b1, opt[1], ~p1.coin, 1'b1};
				c1 = {3'b001, ~p2.fire1, stick_nibble(p2)};
				c2 = {busy, 2'b01, ~p1.fire1, stick_nibble(p1)};
			end
			// Wizard of Wor, second fire not inverted
			8'd5: begin
				c0 = {opt[2], ~p2.start, ~p1.start, 1'b1, opt[1], 1'b1, ~p1.coin, 1'b1};
				c1 = {2'b11, ~p2.fire1, p2.fire2, stick_nibble(p2)};
				c2 = {busy, 1'b1, ~p1.fire1, p1.fire2, stick_nibble(p1)};
			end
			// Robby Roto
			8'd6: begin
				c0 = {1'b0, ~p2.start, ~p1.start, 1'b1, opt[1], 1'b1, ~p1.coin, 1'b1};
				c1 = {2'b11, ~p2.fire1, 1'b1, stick_nibble(p2)};
				c2 = {2'b11, ~p1.fire1, 1'b1, stick_nibble(p1)};
			end
			default: return 8'hFF;
		endcase
		case (col)
			8'h01: return c0;
			8'h02: return c1;
			8'h04: return c2;
			8'h08: return bank3;
			default: return 8'hFF;
		endcase
	endfunction

	task automatic check_value(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %02h actual %02h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

`endif

/* tb_astro_input.sv */
/* Player input testbench
   Drives config bus, keyboard and joysticks, checks every row read */

module tb_astro_input;

	timeunit 1ns;
	timeprecision 1ps;

	// Roughly 1700 cycles of tests, limit leaves about double
	localparam int CYCLE_LIMIT = 4000;

	logic                   clk_sys;
	logic                   reset;
	astro_bus_pkg::wb_req_t wb_req;
	astro_bus_pkg::wb_rsp_t wb_rsp;
	logic [10:0]            ps2_key;
	logic [15:0]            joystick_0;
	logic [15:0]            joystick_1;
	logic                   speech_busy;
	logic [7:0]             col_select;
	logic [7:0]             row_data;

	// Model state
	logic [7:0]  model_dip [8];
	logic [7:0]  model_game;
	logic [17:0] key_held;
	int          seed;
	int          cycle_count;
	string       test_name;

	`include "tb_astro_input_ref.svh"

	astro_input_top i_astro_input_top (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.ps2_key     (ps2_key),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.speech_busy (speech_busy),
		.col_select  (col_select),
		.row_data    (row_data)
	);

	always #4 clk_sys = ~clk_sys;

	// ====================
	// Keyboard model
	// ====================

	// Key order shared by the held-key vector
	function automatic logic [8:0] key_code(input int idx);
		case (idx)
			0: return astro_ctrl_pkg::KEY_UP;
			1: return astro_ctrl_pkg::KEY_DOWN;
			2: return astro_ctrl_pkg::KEY_LEFT;
			3: return astro_ctrl_pkg::KEY_RIGHT;
			4: return astro_ctrl_pkg::KEY_CTRL;
			5: return astro_ctrl_pkg::KEY_SPACE;
			6: return astro_ctrl_pkg::KEY_F1;
			7: return astro_ctrl_pkg::KEY_F2;
			8: return astro_ctrl_pkg::KEY_F3;
			9: return astro_ctrl_pkg::KEY_1;
			10: return astro_ctrl_pkg::KEY_2;
			11: return astro_ctrl_pkg::KEY_5;
			12: return astro_ctrl_pkg::KEY_R;
			13: return astro_ctrl_pkg::KEY_F;
			14: return astro_ctrl_pkg::KEY_D;
			15: return astro_ctrl_pkg::KEY_G;
			16: return astro_ctrl_pkg::KEY_A;
			default: return astro_ctrl_pkg::KEY_S;
		endcase
	endfunction

	// Player 1, keys ORed with stick 0
	function automatic astro_ctrl_pkg::player_btn_t model_p1();
		astro_ctrl_pkg::player_btn_t b;
		b.up    = key_held[0] | joystick_0[3];
		b.down  = key_held[1] | joystick_0[2];
		b.left  = key_held[2] | joystick_0[1];
		b.right = key_held[3] | joystick_0[0];
		b.fire1 = key_held[4] | joystick_0[4];
		b.fire2 = key_held[5] | joystick_0[5];
		b.start = key_held[6] | key_held[9] | joystick_0[6];
		b.coin  = key_held[8] | key_held[11] | joystick_0[8];
		b.pad   = 1'b0;
		return b;
	endfunction

	// Player 2, start button sits on stick 0
	function automatic astro_ctrl_pkg::player_btn_t model_p2();
		astro_ctrl_pkg::player_btn_t b;
		b.up    = key_held[12] | joystick_1[3];
		b.down  = key_held[13] | joystick_1[2];
		b.left  = key_held[14] | joystick_1[1];
		b.right = key_held[15] | joystick_1[0];
		b.fire1 = key_held[16] | joystick_1[4];
		b.fire2 = key_held[17] | joystick_1[5];
		b.start = key_held[7] | key_held[10] | joystick_0[7];
		b.coin  = 1'b0;
		b.pad   = 1'b0;
		return b;
	endfunction

	// ====================
	// Stimulus tasks
	// ====================

	// One Wishbone classic cycle, waits for ack
	task automatic wb_transfer(input logic we, input logic [4:0] adr,
		input logic [7:0] wdata, output logic [7:0] rdata);
		int waited;
		@(posedge clk_sys);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
		waited = 0;
		do begin
			@(negedge clk_sys);
			waited++;
			if (waited > 16) begin
				$display("Wishbone slave never acknowledged address %0d", adr);
				$display("Simulation failed");
				$fatal(1, "no ack");
			end
		end while (!wb_rsp.ack);
		rdata = wb_rsp.dat_r;
		// Ack edge, write lands here
		@(posedge clk_sys);
		wb_req <= '0;
		if (we && adr < 5'(astro_bus_pkg::DIP_BANKS)) begin
			model_dip[adr[2:0]] = wdata;
		end else if (we && adr == 5'(astro_bus_pkg::CFG_ADR_GAME)) begin
			model_game = wdata;
		end
		@(negedge clk_sys);
		check_value("single ack", 8'h00, {7'b0, wb_rsp.ack});
	endtask

	// Key event; the model follows one edge later, as the decoder does
	task automatic send_key(input int idx, input logic make, input logic strip_prefix);
		logic [8:0] code;
		code = key_code(idx);
		if (strip_prefix) begin
			code[8] = 1'b0;
		end
		@(posedge clk_sys);
		ps2_key <= {~ps2_key[10], make, code};
		@(posedge clk_sys);
		key_held[idx] = make;
	endtask

	// Four listed columns and one unlisted
	task automatic sweep_columns();
		logic [7:0] cols [5];
		cols = '{8'h01, 8'h02, 8'h04, 8'h08, 8'h10};
		foreach (cols[c]) begin
			@(posedge clk_sys);
			col_select <= cols[c];
		end
	endtask

	task automatic random_sticks();
		logic [31:0] rnd;
		rnd = $random(seed);
		@(posedge clk_sys);
		joystick_0  <= rnd[15:0];
		joystick_1  <= rnd[31:16];
		rnd = $random(seed);
		speech_busy <= rnd[0];
	endtask

	// ====================
	// Compare and timeout
	// ====================

	always @(negedge clk_sys) begin
		if (!reset) begin
			check_value(test_name,
				expected_row(model_game, col_select, model_dip[2], model_dip[3],
					model_p1(), model_p2(), speech_busy),
				row_data);
		end
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, tests did not finish", cycle_count);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	// ====================
	// Test sequence
	// ====================

	initial begin
		logic [7:0]  rd;
		logic [31:0] rnd;
		seed = 32'hb39d;
		clk_sys = 1'b0;
		reset = 1'b1;
		wb_req = '0;
		ps2_key = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		speech_busy = 1'b0;
		col_select = 8'h01;
		foreach (model_dip[i]) begin
			model_dip[i] = 8'h00;
		end
		model_game = 8'h00;
		key_held = '0;
		cycle_count = 0;
		test_name = "reset defaults";
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;

		sweep_columns();
		wb_transfer(1'b0, 5'd2, 8'h00, rd);
		check_value("reset dip read", 8'h00, rd);
		wb_transfer(1'b0, 5'(astro_bus_pkg::CFG_ADR_GAME), 8'h00, rd);
		check_value("reset game read", 8'h00, rd);

		test_name = "register round trip";
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			wb_transfer(1'b1, 5'(i), rnd[7:0], rd);
			wb_transfer(1'b0, 5'(i), 8'h00, rd);
			check_value("dip round trip", rnd[7:0], rd);
		end
		rnd = $random(seed);
		wb_transfer(1'b1, 5'(astro_bus_pkg::CFG_ADR_GAME), rnd[7:0], rd);
		wb_transfer(1'b0, 5'(astro_bus_pkg::CFG_ADR_GAME), 8'h00, rd);
		check_value("game round trip", rnd[7:0], rd);
		// Holes ignore writes
		wb_transfer(1'b1, 5'd9, 8'h5A, rd);
		wb_transfer(1'b0, 5'd9, 8'h00, rd);
		check_value("unused address read", 8'h00, rd);
		wb_transfer(1'b1, 5'd20, 8'hA5, rd);
		wb_transfer(1'b0, 5'd20, 8'h00, rd);
		check_value("unused address read", 8'h00, rd);

		test_name = "joystick rows";
		for (int g = 3; g <= 6; g++) begin
			wb_transfer(1'b1, 5'(astro_bus_pkg::CFG_ADR_GAME), 8'(g), rd);
			rnd = $random(seed);
			wb_transfer(1'b1, 5'd2, rnd[7:0], rd);
			wb_transfer(1'b1, 5'd3, rnd[15:8], rd);
			repeat (20) begin
				random_sticks();
				sweep_columns();
			end
		end

		test_name = "keyboard buttons";
		@(posedge clk_sys);
		joystick_0  <= '0;
		joystick_1  <= '0;
		speech_busy <= 1'b0;
		for (int g = 3; g <= 6; g++) begin
			wb_transfer(1'b1, 5'(astro_bus_pkg::CFG_ADR_GAME), 8'(g), rd);
			for (int k = 0; k < 18; k++) begin
				// Cursor press keeps the E0 prefix, release drops it
				send_key(k, 1'b1, 1'b0);
				sweep_columns();
				send_key(k, 1'b0, k < 4);
				sweep_columns();
			end
		end

		test_name = "dropped and unknown games";
		for (int k = 0; k < 4; k++) begin
			wb_transfer(1'b1, 5'(astro_bus_pkg::CFG_ADR_GAME), (k == 3) ? 8'd7 : 8'(k), rd);
			random_sticks();
			sweep_columns();
		end

		// Last column still gets its compare
		repeat (2) @(posedge clk_sys);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* astro_input_top.sv */
/* Player input top level
   Config registers, keyboard decoder and switch matrix */

module astro_input_top (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  astro_bus_pkg::wb_req_t wb_req,
	output astro_bus_pkg::wb_rsp_t wb_rsp,
	input  logic [10:0]            ps2_key,
	input  logic [15:0]            joystick_0,
	input  logic [15:0]            joystick_1,
	input  logic                   speech_busy,
	input  logic [7:0]             col_select,
	output logic [7:0]             row_data
);

	// Config to matrix
	logic [astro_bus_pkg::DIP_BANKS-1:0][7:0] dip;
	astro_ctrl_pkg::game_id_t                 game;
	// Decoder to matrix
	astro_ctrl_pkg::player_btn_t              kbd_p1;
	astro_ctrl_pkg::player_btn_t              kbd_p2;

	host_config_regs i_host_config_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.wb_req  (wb_req),
		.wb_rsp  (wb_rsp),
		.dip     (dip),
		.game    (game)
	);

	ps2_button_decoder i_ps2_button_decoder (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ps2_key (ps2_key),
		.kbd_p1  (kbd_p1),
		.kbd_p2  (kbd_p2)
	);

	switch_matrix i_switch_matrix (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dip         (dip),
		.game        (game),
		.kbd_p1      (kbd_p1),
		.kbd_p2      (kbd_p2),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.speech_busy (speech_busy),
		.col_select  (col_select),
		.row_data    (row_data)
	);

endmodule

/* switch_matrix.sv */
/* Switch matrix
   Merges keys with joysticks and answers the selected column per game */

module switch_matrix (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  logic [astro_bus_pkg::DIP_BANKS-1:0][7:0] dip,
	input  astro_ctrl_pkg::game_id_t                game,
	input  astro_ctrl_pkg::player_btn_t             kbd_p1,
	input  astro_ctrl_pkg::player_btn_t             kbd_p2,
	input  logic [15:0]                             joystick_0,
	input  logic [15:0]                             joystick_1,
	input  logic                                    speech_busy,
	input  logic [7:0]                              col_select,
	output logic [7:0]                              row_data
);

	astro_ctrl_pkg::player_btn_t b1;
	astro_ctrl_pkg::player_btn_t b2;
	logic [7:0] d2;
	logic [7:0] row0;
	logic [7:0] row1;
	logic [7:0] row2;
	logic       game_known;

	// ====================
	// Button merge
	// ====================

	// Stick bits 0..5 are R, L, D, U, fire1, fire2
	always_comb begin
		b1.right = kbd_p1.right | joystick_0[0];
		b1.left  = kbd_p1.left  | joystick_0[1];
		b1.down  = kbd_p1.down  | joystick_0[2];
		b1.up    = kbd_p1.up    | joystick_0[3];
		b1.fire1 = kbd_p1.fire1 | joystick_0[4];
		b1.fire2 = kbd_p1.fire2 | joystick_0[5];
		// Start and coin buttons live on stick 0 only
		b1.start = kbd_p1.start | joystick_0[6];
		b1.coin  = kbd_p1.coin  | joystick_0[8];
		b1.pad   = 1'b0;

		b2.right = kbd_p2.right | joystick_1[0];
		b2.left  = kbd_p2.left  | joystick_1[1];
		b2.down  = kbd_p2.down  | joystick_1[2];
		b2.up    = kbd_p2.up    | joystick_1[3];
		b2.fire1 = kbd_p2.fire1 | joystick_1[4];
		b2.fire2 = kbd_p2.fire2 | joystick_1[5];
		b2.start = kbd_p2.start | joystick_0[7];
		b2.coin  = kbd_p2.coin;
		b2.pad   = 1'b0;
	end

	// Game option bank
	assign d2 = dip[2];

	// ====================
	// Per-game rows
	// ====================

	// Switches pull low when closed, so buttons are inverted
	always_comb begin
		game_known = 1'b1;
		row0 = astro_ctrl_pkg::ROW_IDLE;
		row1 = astro_ctrl_pkg::ROW_IDLE;
		row2 = astro_ctrl_pkg::ROW_IDLE;
		case (game)
			astro_ctrl_pkg::space_zap: begin
				row0 = {2'b11, ~b2.start, ~b1.start, d2[1], 1'b1, ~b1.coin, 1'b1};
				row1 = {3'b111, ~b2.fire1, ~b2.right, ~b2.left, ~b2.down, ~b2.up};
				row2 = {2'b11, d2[0], ~b1.fire1, ~b1.right, ~b1.left, ~b1.down, ~b1.up};
			end
			astro_ctrl_pkg::wow: begin
				// Second fire reads active high on this board
				row0 = {d2[2], ~b2.start, ~b1.start, 1'b1, d2[1], 1'b1, ~b1.coin, 1'b1};
				row1 = {2'b11, ~b2.fire1, b2.fire2, ~b2.right, ~b2.left, ~b2.down, ~b2.up};
				row2 = {speech_busy, 1'b1, ~b1.fire1, b1.fire2,
					~b1.right, ~b1.left, ~b1.down, ~b1.up};
			end
			astro_ctrl_pkg::gorf: begin
				row0 = {d2[2], d2[0], ~b2.start, ~b1.start, 1'b1, d2[1], ~b1.coin, 1'b1};
				row1 = {3'b001, ~b2.fire1, ~b2.right, ~b2.left, ~b2.down, ~b2.up};
				row2 = {speech_busy, 2'b01, ~b1.fire1, ~b1.right, ~b1.left, ~b1.down, ~b1.up};
			end
			astro_ctrl_pkg::robby: begin
				row0 = {1'b0, ~b2.start, ~b1.start, 1'b1, d2[1], 1'b1, ~b1.coin, 1'b1};
				row1 = {2'b11, ~b2.fire1, 1'b1, ~b2.right, ~b2.left, ~b2.down, ~b2.up};
				row2 = {2'b11, ~b1.fire1, 1'b1, ~b1.right, ~b1.left, ~b1.down, ~b1.up};
			end
			default: begin
				// Dropped and unknown games
				game_known = 1'b0;
			end
		endcase
	end

	// ====================
	// Column select
	// ====================

	always_comb begin
		row_data = astro_ctrl_pkg::ROW_IDLE;
		if (game_known) begin
			case (col_select)
				astro_ctrl_pkg::COL_0: row_data = row0;
				astro_ctrl_pkg::COL_1: row_data = row1;
				astro_ctrl_pkg::COL_2: row_data = row2;
				// Column 3 is a plain DIP bank
				astro_ctrl_pkg::COL_3: row_data = dip[3];
				default: row_data = astro_ctrl_pkg::ROW_IDLE;
			endcase
		end
	end

	// CPU must never read a floating row
	a_row_known: assert property (@(posedge clk_sys) disable iff (reset)
		!$isunknown(row_data));

endmodule

/* ps2_button_decoder.sv */
/* PS/2 button decoder
   Tracks key make and break events as held buttons for two players */

module ps2_button_decoder (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic [10:0]                 ps2_key,
	output astro_ctrl_pkg::player_btn_t kbd_p1,
	output astro_ctrl_pkg::player_btn_t kbd_p2
);

	// One bit per decoded key
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic ctrl;
		logic space;
		logic f1;
		logic f2;
		logic f3;
		logic k1;
		logic k2;
		logic k5;
		logic r;
		logic f;
		logic d;
		logic g;
		logic a;
		logic s;
	} key_held_t;

	logic       toggle_last;
	logic       key_event;
	logic       pressed;
	logic [8:0] code;
	key_held_t  hit;
	key_held_t  held;

	// Event fields
	assign pressed   = ps2_key[9];
	assign code      = ps2_key[8:0];
	// Bit 10 flips once per key event
	assign key_event = (ps2_key[10] != toggle_last);

	// ====================
	// Key match
	// ====================

	always_comb begin
		hit = '0;
		// Cursor keys match with or without the E0 prefix
		hit.up    = (code[7:0] == 8'(astro_ctrl_pkg::KEY_UP));
		hit.down  = (code[7:0] == 8'(astro_ctrl_pkg::KEY_DOWN));
		hit.left  = (code[7:0] == 8'(astro_ctrl_pkg::KEY_LEFT));
		hit.right = (code[7:0] == 8'(astro_ctrl_pkg::KEY_RIGHT));
		// Everything else needs the full code
		hit.ctrl  = (code == astro_ctrl_pkg::KEY_CTRL);
		hit.space = (code == astro_ctrl_pkg::KEY_SPACE);
		hit.f1    = (code == astro_ctrl_pkg::KEY_F1);
		hit.f2    = (code == astro_ctrl_pkg::KEY_F2);
		hit.f3    = (code == astro_ctrl_pkg::KEY_F3);
		hit.k1    = (code == astro_ctrl_pkg::KEY_1);
		hit.k2    = (code == astro_ctrl_pkg::KEY_2);
		hit.k5    = (code == astro_ctrl_pkg::KEY_5);
		hit.r     = (code == astro_ctrl_pkg::KEY_R);
		hit.f     = (code == astro_ctrl_pkg::KEY_F);
		hit.d     = (code == astro_ctrl_pkg::KEY_D);
		hit.g     = (code == astro_ctrl_pkg::KEY_G);
		hit.a     = (code == astro_ctrl_pkg::KEY_A);
		hit.s     = (code == astro_ctrl_pkg::KEY_S);
	end

	// ====================
	// Held state
	// ====================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_last <= 1'b0;
			held        <= '0;
		end else begin
			toggle_last <= ps2_key[10];
			if (key_event) begin
				// Make sets the matched key, break clears it
				held <= pressed ? (held | hit) : (held & ~hit);
			end
		end
	end

	// Two keys may share one button, so they are ORed
	always_comb begin
		kbd_p1.up    = held.up;
		kbd_p1.down  = held.down;
		kbd_p1.left  = held.left;
		kbd_p1.right = held.right;
		kbd_p1.fire1 = held.ctrl;
		kbd_p1.fire2 = held.space;
		kbd_p1.start = held.f1 | held.k1;
		kbd_p1.coin  = held.f3 | held.k5;
		kbd_p1.pad   = 1'b0;

		kbd_p2.up    = held.r;
		kbd_p2.down  = held.f;
		kbd_p2.left  = held.d;
		kbd_p2.right = held.g;
		kbd_p2.fire1 = held.a;
		kbd_p2.fire2 = held.s;
		kbd_p2.start = held.f2 | held.k2;
		// Single coin slot, wired to player 1
		kbd_p2.coin  = 1'b0;
		kbd_p2.pad   = 1'b0;
	end

endmodule

/* host_config_regs.sv */
/* Host configuration registers
   Wishbone classic slave holding the DIP banks and the game identifier */

module host_config_regs (
	input  logic                                    clk_sys,
	input  logic                                    reset,
	input  astro_bus_pkg::wb_req_t                  wb_req,
	output astro_bus_pkg::wb_rsp_t                  wb_rsp,
	output logic [astro_bus_pkg::DIP_BANKS-1:0][7:0] dip,
	output astro_ctrl_pkg::game_id_t                game
);

	// ====================
	// Sequencer
	// ====================

	typedef enum logic {
		ST_IDLE,
		ST_ACK
	} state_t;

	state_t state;
	logic   ack;
	logic   dip_sel;
	logic   game_sel;
	logic   wr_strobe;
	logic   [2:0] dip_idx;

	// Idle until a cycle starts then one ack cycle
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (wb_req.cyc && wb_req.stb) begin
						state <= ST_ACK;
					end
				end
				default: begin
					// Master drops stb after ack
					state <= ST_IDLE;
				end
			endcase
		end
	end

	assign ack = (state == ST_ACK);

	// ====================
	// Address decode
	// ====================

	// DIP banks sit at base .. base+7
	assign dip_sel = (int'(wb_req.adr) >= astro_bus_pkg::CFG_ADR_DIP_BASE) &&
		(int'(wb_req.adr) < astro_bus_pkg::CFG_ADR_DIP_BASE + astro_bus_pkg::DIP_BANKS);
	assign game_sel = (int'(wb_req.adr) == astro_bus_pkg::CFG_ADR_GAME);
	// Bank offset inside the DIP window
	assign dip_idx = 3'(int'(wb_req.adr) - astro_bus_pkg::CFG_ADR_DIP_BASE);

	// Write lands on the ack edge
	assign wr_strobe = ack && wb_req.cyc && wb_req.stb && wb_req.we;

	// ====================
	// Storage
	// ====================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dip  <= '0;
			game <= astro_ctrl_pkg::none;
		end else if (wr_strobe) begin
			if (dip_sel) begin
				dip[dip_idx] <= wb_req.dat_w;
			end else if (game_sel) begin
				// Any byte is kept so unknown ids read back as written
				game <= astro_ctrl_pkg::game_id_t'(wb_req.dat_w);
			end
		end
	end

	// Read mux gives zero for holes and outside ack
	always_comb begin
		wb_rsp.ack   = ack;
		wb_rsp.dat_r = 8'h00;
		if (ack) begin
			if (dip_sel) begin
				wb_rsp.dat_r = dip[dip_idx];
			end else if (game_sel) begin
				wb_rsp.dat_r = 8'(game);
			end
		end
	end

	// ====================
	// Protocol checks
	// ====================

	// Master keeps the request up through the ack cycle
	a_req_held_at_ack: assert property (@(posedge clk_sys) disable iff (reset)
		wb_rsp.ack |-> (wb_req.cyc && wb_req.stb));

	// A held stb after ack would start a second transfer
	a_stb_drop_after_ack: assert property (@(posedge clk_sys) disable iff (reset)
		wb_rsp.ack |=> !wb_req.stb);

endmodule

/* astro_ctrl_pkg.sv */
/* Player control definitions
   Game identifiers, button bundle, PS/2 key codes and switch matrix codes */

package astro_ctrl_pkg;

	// ====================
	// Game identifiers
	// ====================

	// Values match what the host loader writes
	typedef enum logic [7:0] {
		none        = 8'd0,
		extra_bases = 8'd1,
		seawolf2    = 8'd2,
		space_zap   = 8'd3,
		gorf        = 8'd4,
		wow         = 8'd5,
		robby       = 8'd6
	} game_id_t;

	// One player's buttons, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
		logic start;
		logic coin;
		// Spare bit, always zero
		logic pad;
	} player_btn_t;

	// ====================
	// PS/2 key codes
	// ====================

	// Cursor keys carry the E0 prefix in bit 8
	localparam logic [8:0] KEY_UP    = 9'h175;
	localparam logic [8:0] KEY_DOWN  = 9'h172;
	localparam logic [8:0] KEY_LEFT  = 9'h16B;
	localparam logic [8:0] KEY_RIGHT = 9'h174;
	// Player 1 fire buttons
	localparam logic [8:0] KEY_CTRL  = 9'h014;
	localparam logic [8:0] KEY_SPACE = 9'h029;
	// Function keys for start and coin
	localparam logic [8:0] KEY_F1    = 9'h005;
	localparam logic [8:0] KEY_F2    = 9'h006;
	localparam logic [8:0] KEY_F3    = 9'h004;
	// Arcade panel style keys
	localparam logic [8:0] KEY_1     = 9'h016;
	localparam logic [8:0] KEY_2     = 9'h01E;
	localparam logic [8:0] KEY_5     = 9'h02E;
	// Player 2 stick and fire
	localparam logic [8:0] KEY_R     = 9'h02D;
	localparam logic [8:0] KEY_F     = 9'h02B;
	localparam logic [8:0] KEY_D     = 9'h023;
	localparam logic [8:0] KEY_G     = 9'h034;
	localparam logic [8:0] KEY_A     = 9'h01C;
	localparam logic [8:0] KEY_S     = 9'h01B;

	// ====================
	// Switch matrix
	// ====================

	// One-hot column strobes from the CPU
	localparam logic [7:0] COL_0 = 8'h01;
	localparam logic [7:0] COL_1 = 8'h02;
	localparam logic [7:0] COL_2 = 8'h04;
	localparam logic [7:0] COL_3 = 8'h08;
	// Nothing pressed, switches open
	localparam logic [7:0] ROW_IDLE = 8'hFF;

endpackage

/* astro_bus_pkg.sv */
/* Host configuration bus
   Wishbone classic request and response structs and the register map */

package astro_bus_pkg;

	// ====================
	// Bus widths
	// ====================

	// Five address bits cover banks and game register
	localparam int ADR_W = 5;
	// Byte-wide data path
	localparam int DAT_W = 8;

	// ====================
	// Register map
	// ====================

	// First DIP bank, banks follow at consecutive addresses
	localparam int CFG_ADR_DIP_BASE = 0;
	// Number of DIP banks
	localparam int DIP_BANKS = 8;
	// Game identifier register
	localparam int CFG_ADR_GAME = 16;

	// ====================
	// Bus structs
	// ====================

	// Master to slave
	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [ADR_W-1:0] adr;
		logic [DAT_W-1:0] dat_w;
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic             ack;
		logic [DAT_W-1:0] dat_r;
	} wb_rsp_t;

endpackage
